//--- hdl/video_pkg.sv
package video_pkg;

  // *************************************************************************
  // Pixel format and filter arithmetic
  // *************************************************************************

  localparam int PX_WIDTH      = 10;
  localparam int KERNEL_RADIUS = 1;  // Three taps need one padding pixel per side

  // The 1-2-1 weights sum to four, so two guard bits hold the full sum
  localparam int SUM_WIDTH = PX_WIDTH + 2;

  localparam logic [SUM_WIDTH - 1 : 0] ROUND_BIAS = SUM_WIDTH'( 2 );  // Half of the divisor

  // *************************************************************************
  // Stream beat
  // *************************************************************************

  typedef struct packed {
    logic [PX_WIDTH - 1 : 0] data;
    logic                    user;  // Start of frame
    logic                    last;  // End of line
  } video_beat_t;

  // *************************************************************************
  // Filter fill state
  // *************************************************************************

  // FILL0 and FILL1 load the history at a line start
  typedef enum logic [1:0] {
    FILL0,
    FILL1,
    RUN
  } smooth_state_e;

endpackage

//--- hdl/stream_skid_buffer.sv
`timescale 1ns/10ps

module stream_skid_buffer (
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  video_pkg::video_beat_t s_beat_i,
  input  logic                   s_valid_i,
  output logic                   s_ready_o,

  output video_pkg::video_beat_t m_beat_o,
  output logic                   m_valid_o,
  input  logic                   m_ready_i
);

video_pkg::video_beat_t main_q;
video_pkg::video_beat_t spare_q;
logic                   main_valid_q;
logic                   ready_q;       // Low exactly while the spare holds a beat
logic                   main_load;

// Main register may take a new beat when it is empty or being drained
assign main_load = m_ready_i || !main_valid_q;

always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
  begin
    main_valid_q <= 1'b0;
    ready_q      <= 1'b1;
  end
  else if( main_load )
  begin
    if( !ready_q )
    begin
      main_valid_q <= 1'b1;  // Spare drains into main
      ready_q      <= 1'b1;
    end
    else
      main_valid_q <= s_valid_i;
  end
  else if( s_valid_i && ready_q )
    ready_q <= 1'b0;         // Main is stalled so the arriving beat parks in the spare
end

always_ff @( posedge clk_i )
begin
  if( main_load )
    main_q <= ready_q ? s_beat_i : spare_q;
  if( ready_q )
    spare_q <= s_beat_i;
end

assign s_ready_o = ready_q;
assign m_beat_o  = main_q;
assign m_valid_o = main_valid_q;

// A stalled beat must neither change nor vanish
a_stall_stable : assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  m_valid_o && !m_ready_i |=> m_valid_o && $stable( m_beat_o )
);

endmodule

//--- hdl/line_extender.sv
`timescale 1ns/10ps

module line_extender #(
  parameter int LEFT  = 1,
  parameter int RIGHT = 1
)(
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  video_pkg::video_beat_t s_beat_i,
  input  logic                   s_valid_i,
  output logic                   s_ready_o,

  output video_pkg::video_beat_t m_beat_o,
  output logic                   m_valid_o,
  input  logic                   m_ready_i
);

localparam int LEFT_CW  = LEFT == 1 ? 1 : $clog2( LEFT );
localparam int RIGHT_CW = RIGHT == 1 ? 1 : $clog2( RIGHT );

video_pkg::video_beat_t  out_beat_q;
logic                    out_valid_q;
logic                    allow_new_data;  // Input gate, closed while copies play
logic                    line_first;      // Next accepted pixel starts a line
logic [LEFT_CW - 1 : 0]  left_cnt;
logic [RIGHT_CW - 1 : 0] right_cnt;
logic                    left_cnt_en;
logic                    right_cnt_en;
logic                    s_fire;
logic                    left_done;
logic                    right_done;

assign s_ready_o  = allow_new_data && ( !out_valid_q || m_ready_i );
assign s_fire     = s_valid_i && s_ready_o;
assign left_done  = left_cnt_en && left_cnt == LEFT_CW'( LEFT - 1 );
assign right_done = right_cnt_en && right_cnt == RIGHT_CW'( RIGHT - 1 );

// *************************************************************************
// Output register
// *************************************************************************

always_ff @( posedge clk_i )
begin
  if( s_ready_o )
    out_beat_q <= s_beat_i;
end

always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
    out_valid_q <= 1'b0;
  else if( s_ready_o )
    out_valid_q <= s_valid_i;
end

always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
    line_first <= 1'b1;
  else if( s_fire )
    line_first <= s_beat_i.last;
end

// Border pixels close the gate until their copies have been sent
always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
    allow_new_data <= 1'b1;
  else if( s_fire && ( line_first || s_beat_i.last ) )
    allow_new_data <= 1'b0;
  else if( ( left_done || right_done ) && m_ready_i )
    allow_new_data <= 1'b1;
end

// *************************************************************************
// Copy counters
// *************************************************************************

always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
    left_cnt_en <= 1'b0;
  else if( s_fire && line_first )
    left_cnt_en <= 1'b1;
  else if( left_done && m_ready_i )
    left_cnt_en <= 1'b0;
end

always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
    right_cnt_en <= 1'b0;
  else if( s_fire && s_beat_i.last )
    right_cnt_en <= 1'b1;
  else if( right_done && m_ready_i )
    right_cnt_en <= 1'b0;
end

// Output valid stays high during a copy phase, so ready alone marks a transfer
always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
    left_cnt <= LEFT_CW'( 0 );
  else if( m_ready_i )
  begin
    if( left_cnt_en )
      left_cnt <= left_cnt + 1'b1;
    else
      left_cnt <= LEFT_CW'( 0 );
  end
end

always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
    right_cnt <= RIGHT_CW'( 0 );
  else if( m_ready_i )
  begin
    if( right_cnt_en )
      right_cnt <= right_cnt + 1'b1;
    else
      right_cnt <= RIGHT_CW'( 0 );
  end
end

assign m_beat_o.data = out_beat_q.data;
assign m_beat_o.user = !allow_new_data && left_cnt == LEFT_CW'( 0 ) ? out_beat_q.user : 1'b0;
assign m_beat_o.last = allow_new_data ? out_beat_q.last : 1'b0;  // Only the final right copy
assign m_valid_o     = out_valid_q;

a_one_copy_phase : assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  !( left_cnt_en && right_cnt_en )
);

// Frame start belongs to the first padded beat and never to a copy
a_sof_not_on_copy : assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  m_valid_o && m_ready_i && m_beat_o.user |=> left_cnt != LEFT_CW'( 0 ) && !m_beat_o.user
);

endmodule

//--- hdl/hor_smooth_filter.sv
`timescale 1ns/10ps

module hor_smooth_filter (
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  video_pkg::video_beat_t s_beat_i,
  input  logic                   s_valid_i,
  output logic                   s_ready_o,

  output video_pkg::video_beat_t m_beat_o,
  output logic                   m_valid_o,
  input  logic                   m_ready_i
);

video_pkg::smooth_state_e                state_q;
logic [video_pkg::PX_WIDTH - 1 : 0]      older_q;
logic [video_pkg::PX_WIDTH - 1 : 0]      newer_q;
logic                                    user_pend_q;  // Frame start seen during fill
video_pkg::video_beat_t                  out_beat_q;
logic                                    out_valid_q;
logic                                    s_fire;
logic                                    m_fire;
logic                                    produce;
logic [video_pkg::SUM_WIDTH - 1 : 0]     sum;

// Fill beats never touch the output register, so only RUN waits on it
assign s_ready_o = state_q != video_pkg::RUN || !out_valid_q || m_ready_i;
assign s_fire    = s_valid_i && s_ready_o;
assign m_fire    = out_valid_q && m_ready_i;
assign produce   = s_fire && state_q == video_pkg::RUN;

// *************************************************************************
// One-two-one kernel
// *************************************************************************

assign sum = { 2'b00, older_q } + { 1'b0, newer_q, 1'b0 } + { 2'b00, s_beat_i.data } +
             video_pkg::ROUND_BIAS;

always_ff @( posedge clk_i )
begin
  if( s_fire )
  begin
    older_q <= newer_q;
    newer_q <= s_beat_i.data;
  end
end

always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
    state_q <= video_pkg::FILL0;
  else if( s_fire )
  begin
    case( state_q )
      video_pkg::FILL0 : state_q <= video_pkg::FILL1;
      video_pkg::FILL1 : state_q <= video_pkg::RUN;
      default :
      begin
        if( s_beat_i.last )
          state_q <= video_pkg::FILL0;  // Padded line done, refill for the next one
      end
    endcase
  end
end

always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
    user_pend_q <= 1'b0;
  else if( s_fire )
  begin
    if( state_q == video_pkg::RUN )
      user_pend_q <= 1'b0;
    else
      user_pend_q <= user_pend_q || s_beat_i.user;
  end
end

// *************************************************************************
// Output register
// *************************************************************************

always_ff @( posedge clk_i )
begin
  if( produce )
  begin
    out_beat_q.data <= sum[video_pkg::SUM_WIDTH - 1 : 2];  // Divide by four
    out_beat_q.user <= user_pend_q;
    out_beat_q.last <= s_beat_i.last;
  end
end

always_ff @( posedge clk_i, posedge rst_i )
begin
  if( rst_i )
    out_valid_q <= 1'b0;
  else if( produce )
    out_valid_q <= 1'b1;
  else if( m_fire )
    out_valid_q <= 1'b0;
end

assign m_beat_o  = out_beat_q;
assign m_valid_o = out_valid_q;

// The extender places frame start on the first padded beat, which lands in FILL0
a_no_sof_in_run : assert property (
  @( posedge clk_i ) disable iff ( rst_i )
  s_fire && s_beat_i.user |-> state_q != video_pkg::RUN
);

endmodule

//--- hdl/video_smooth_top.sv
`timescale 1ns/10ps

module video_smooth_top (
  input  logic                   clk_i,
  input  logic                   rst_i,

  input  video_pkg::video_beat_t in_beat_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,

  output video_pkg::video_beat_t out_beat_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i
);

video_pkg::video_beat_t skid_beat;
logic                   skid_valid;
logic                   skid_ready;

video_pkg::video_beat_t ext_beat;
logic                   ext_valid;
logic                   ext_ready;

// Registered ready toward the outside world
stream_skid_buffer u_skid (
  .clk_i     ( clk_i      ),
  .rst_i     ( rst_i      ),
  .s_beat_i  ( in_beat_i  ),
  .s_valid_i ( in_valid_i ),
  .s_ready_o ( in_ready_o ),
  .m_beat_o  ( skid_beat  ),
  .m_valid_o ( skid_valid ),
  .m_ready_i ( skid_ready )
);

line_extender #(
  .LEFT  ( video_pkg::KERNEL_RADIUS ),
  .RIGHT ( video_pkg::KERNEL_RADIUS )
) u_ext (
  .clk_i     ( clk_i      ),
  .rst_i     ( rst_i      ),
  .s_beat_i  ( skid_beat  ),
  .s_valid_i ( skid_valid ),
  .s_ready_o ( skid_ready ),
  .m_beat_o  ( ext_beat   ),
  .m_valid_o ( ext_valid  ),
  .m_ready_i ( ext_ready  )
);

hor_smooth_filter u_filter (
  .clk_i     ( clk_i       ),
  .rst_i     ( rst_i       ),
  .s_beat_i  ( ext_beat    ),
  .s_valid_i ( ext_valid   ),
  .s_ready_o ( ext_ready   ),
  .m_beat_o  ( out_beat_o  ),
  .m_valid_o ( out_valid_o ),
  .m_ready_i ( out_ready_i )
);

endmodule

//--- bench/video_smooth_tb.sv
`timescale 1ns/10ps

module video_smooth_tb;

typedef logic [video_pkg::PX_WIDTH - 1 : 0] pixel_t;
typedef pixel_t pix_q_t[$];

localparam int LINES         = 4;
localparam int LINE_W        = 16;
localparam int BORDER_LINES  = 4;
localparam int BORDER_W      = 8;
localparam int FRAMING_BEATS = 2 + 3 + 7 + 16;
localparam int FRAMES        = 3;
localparam int SHORT_LINES   = 2;
localparam int SHORT_W       = 5;
localparam int TOTAL_BEATS   = LINES * LINE_W + BORDER_LINES * BORDER_W + FRAMING_BEATS +
                               FRAMES * SHORT_LINES * SHORT_W + FRAMES * LINES * LINE_W;
localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 8 + 200;

logic                   clk_i;
logic                   rst_i;
video_pkg::video_beat_t in_beat_i;
logic                   in_valid_i;
logic                   in_ready_o;
video_pkg::video_beat_t out_beat_o;
logic                   out_valid_o;
logic                   out_ready_i;

video_pkg::video_beat_t exp_q[$];
int                     exp_len_q[$];
video_pkg::video_beat_t exp_beat;
int                     errors = 0;
int                     checked = 0;
int                     line_beats = 0;
int                     cycles = 0;
bit                     stall_en = 1'b0;  // Random lows on out_ready_i when set

video_smooth_top UUT (
  .clk_i       ( clk_i       ),
  .rst_i       ( rst_i       ),
  .in_beat_i   ( in_beat_i   ),
  .in_valid_i  ( in_valid_i  ),
  .in_ready_o  ( in_ready_o  ),
  .out_beat_o  ( out_beat_o  ),
  .out_valid_o ( out_valid_o ),
  .out_ready_i ( out_ready_i )
);

initial
begin
  clk_i = 1'b0;
  forever #50 clk_i = ~clk_i;
end

// *************************************************************************
// Reference model
// *************************************************************************

// Pads with repeated end pixels, then takes the rounded 1-2-1 average
function automatic pix_q_t smooth_line(input pix_q_t line);
  pix_q_t padded;
  pix_q_t result;
  int     sum;
  int     i;
  for (i = 0; i < video_pkg::KERNEL_RADIUS; i++)
    padded.push_back(line[0]);
  for (i = 0; i < line.size(); i++)
    padded.push_back(line[i]);
  for (i = 0; i < video_pkg::KERNEL_RADIUS; i++)
    padded.push_back(line[line.size() - 1]);
  for (i = 0; i < line.size(); i++)
  begin
    sum = int'(padded[i + video_pkg::KERNEL_RADIUS - 1]) +
          2 * int'(padded[i + video_pkg::KERNEL_RADIUS]) +
          int'(padded[i + video_pkg::KERNEL_RADIUS + 1]) + 2;
    result.push_back(pixel_t'(sum / 4));
  end
  return result;
endfunction

function automatic pixel_t random_pixel();
  return pixel_t'($urandom % (1 << video_pkg::PX_WIDTH));
endfunction

// *************************************************************************
// Compare tasks
// *************************************************************************

task automatic check_beat(input video_pkg::video_beat_t expected,
                          input video_pkg::video_beat_t actual);
  video_pkg::smooth_state_e state;
  state = UUT.u_filter.state_q;
  if (actual.data !== expected.data)
  begin
    $display("error %0t out_beat_o.data expected %0d actual %0d (filter %s)",
             $time, expected.data, actual.data, state.name());
    errors++;
  end
  if (actual.user !== expected.user)
  begin
    $display("error %0t out_beat_o.user expected %0b actual %0b (filter %s)",
             $time, expected.user, actual.user, state.name());
    errors++;
  end
  if (actual.last !== expected.last)
  begin
    $display("error %0t out_beat_o.last expected %0b actual %0b (filter %s)",
             $time, expected.last, actual.last, state.name());
    errors++;
  end
endtask

task automatic check_count(input int expected, input int actual);
  if (actual != expected)
  begin
    $display("error %0t line_length expected %0d actual %0d", $time, expected, actual);
    errors++;
  end
endtask

// *************************************************************************
// Stimulus
// *************************************************************************

// Called 10 ns after an edge, returns 10 ns after the edge that took the beat
task automatic drive_beat(input video_pkg::video_beat_t beat);
  in_beat_i  = beat;
  in_valid_i = 1'b1;
  while (!in_ready_o)
  begin
    @(posedge clk_i);
    #10;
  end
  @(posedge clk_i);
  #10;
endtask

task automatic send_line(input pix_q_t line, input bit sof, input bit gaps);
  pix_q_t                 expected;
  video_pkg::video_beat_t beat;
  int                     i;
  expected = smooth_line(line);
  for (i = 0; i < expected.size(); i++)
  begin
    beat.data = expected[i];
    beat.user = sof && i == 0;             // Frame start on the first output only
    beat.last = i == expected.size() - 1;
    exp_q.push_back(beat);
  end
  exp_len_q.push_back(line.size());
  for (i = 0; i < line.size(); i++)
  begin
    if (gaps && $urandom % 4 == 0)
    begin
      in_valid_i = 1'b0;
      repeat (1 + $urandom % 3)
      begin
        @(posedge clk_i);
        #10;
      end
    end
    beat.data = line[i];
    beat.user = sof && i == 0;
    beat.last = i == line.size() - 1;
    drive_beat(beat);
  end
  in_valid_i = 1'b0;
endtask

task automatic send_frame(input int lines, input int width, input bit gaps);
  pix_q_t line;
  int     l;
  int     p;
  for (l = 0; l < lines; l++)
  begin
    line = {};
    for (p = 0; p < width; p++)
      line.push_back(random_pixel());
    send_line(line, l == 0, gaps);
  end
endtask

// Extremes at both ends with mid values next to them
task automatic send_border_frame();
  pix_q_t line;
  int     l;
  int     p;
  for (l = 0; l < BORDER_LINES; l++)
  begin
    line = {};
    line.push_back(l % 2 == 0 ? pixel_t'(0) : pixel_t'(1023));
    for (p = 1; p < BORDER_W - 1; p++)
      line.push_back(pixel_t'(448 + $urandom % 128));
    line.push_back(l % 2 == 0 ? pixel_t'(1023) : pixel_t'(0));
    send_line(line, l == 0, 1'b0);
  end
endtask

task automatic send_framing_frame();
  int     widths[4];
  pix_q_t line;
  int     l;
  int     p;
  widths = '{2, 3, 7, 16};
  for (l = 0; l < 4; l++)
  begin
    line = {};
    for (p = 0; p < widths[l]; p++)
      line.push_back(random_pixel());
    send_line(line, l == 0, 1'b0);
  end
endtask

initial
begin
  forever
  begin
    @(posedge clk_i);
    #10;
    out_ready_i = stall_en ? ($urandom % 4 != 0) : 1'b1;
  end
end

// Outputs are registered, so the falling edge sees the coming transfer
always @(negedge clk_i)
begin
  if (!rst_i && out_valid_o && out_ready_i)
  begin
    if (exp_q.size() == 0)
    begin
      $display("Output beat at %0t arrived with no expected beat left", $time);
      errors++;
    end
    else
    begin
      exp_beat = exp_q.pop_front();
      check_beat(exp_beat, out_beat_o);
    end
    checked++;
    line_beats++;
    if (out_beat_o.last)
    begin
      if (exp_len_q.size() == 0)
      begin
        $display("Line end at %0t arrived with no line expected", $time);
        errors++;
      end
      else
        check_count(exp_len_q.pop_front(), line_beats);
      line_beats = 0;
    end
  end
end

initial
begin
  while (cycles < TIMEOUT_CYCLES)
  begin
    @(posedge clk_i);
    cycles++;
  end
  $display("Timeout after %0d cycles with %0d beats still expected", cycles, exp_q.size());
  errors++;
  $display("Checked %0d beats, errors %0d", checked, errors);
  $display("TESTBENCH FAILED");
  $finish;
end

initial
begin : main_seq
  int f;
  void'($urandom(32'h598f));
  rst_i       = 1'b1;
  in_beat_i   = '0;
  in_valid_i  = 1'b0;
  out_ready_i = 1'b1;
  repeat (10) @(posedge clk_i);
  #10;
  rst_i = 1'b0;

  send_frame(LINES, LINE_W, 1'b0);
  send_border_frame();
  send_framing_frame();
  for (f = 0; f < FRAMES; f++)
    send_frame(SHORT_LINES, SHORT_W, 1'b0);

  stall_en = 1'b1;  // Back-pressure and input gaps from here on
  for (f = 0; f < FRAMES; f++)
    send_frame(LINES, LINE_W, 1'b1);

  while (exp_q.size() != 0)
    @(posedge clk_i);
  repeat (20) @(posedge clk_i);
  if (exp_len_q.size() != 0)
  begin
    $display("%0d line lengths were never seen at the output", exp_len_q.size());
    errors++;
  end

  $display("Checked %0d beats, errors %0d", checked, errors);
  if (errors == 0)
    $display("TESTBENCH PASSED");
  else
    $display("TESTBENCH FAILED");
  $finish;
end

endmodule

//--- src.f
hdl/video_pkg.sv
hdl/stream_skid_buffer.sv
hdl/line_extender.sv
hdl/hor_smooth_filter.sv
hdl/video_smooth_top.sv
bench/video_smooth_tb.sv

//--- Bender.yml
package:
  name: video_smooth

sources:
  - files:
      - hdl/video_pkg.sv
      - hdl/stream_skid_buffer.sv
      - hdl/line_extender.sv
      - hdl/hor_smooth_filter.sv
      - hdl/video_smooth_top.sv

  - target: test
    files:
      - bench/video_smooth_tb.sv

# Simulation top level: video_smooth_tb
# Synthesis top level: video_smooth_top
